// ==== build.f ====
+incdir+.
hsci_pkg.sv
hsci_regs.sv
hsci_buffer.sv
hsci_bit_timer.sv
hsci_xfer_fsm.sv
hsci_lane_shifter.sv
hsci_master_top.sv
tb_hsci_master.sv

// ==== hsci_bit_timer.sv ====
// start and stop never come in the same cycle; a turn_start while counting restarts the wait
`timescale 1ns/10ps
`default_nettype none
`include "hsci_config.svh"

module hsci_bit_timer import hsci_pkg::*; (
  input  logic       hsci_pclk,
  input  logic       rst_n,
  input  logic       start,
  input  logic       turn_start,
  input  logic       stop,
  output hsci_slot_t slot
);

  localparam int TW = $clog2(`HSCI_TURN_CYCLES + 1);

  logic          active_q;
  logic [2:0]    slot_q;
  logic [TW-1:0] turn_q;

  always_ff @(posedge hsci_pclk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      slot_q   <= '0;
      turn_q   <= '0;
    end else begin
      // slot 0 lands in the cycle after start
      if (start) begin
        active_q <= 1'b1;
        slot_q   <= 3'd0;
      end else begin
        if (stop)
          active_q <= 1'b0;
        if (active_q)
          slot_q <= (slot_q == 3'd4) ? 3'd0 : slot_q + 3'd1;
      end
      // turnaround down-counter
      if (turn_start)
        turn_q <= TW'(`HSCI_TURN_CYCLES);
      else if (turn_q != '0)
        turn_q <= turn_q - 1'b1;
    end
  end

  // last idle cycle flags turn_done
  always_comb begin
    slot.slot      = slot_q;
    slot.word_end  = active_q && (slot_q == 3'd4);
    slot.turn_done = (turn_q == TW'(1));
  end

endmodule

`default_nettype wire

// ==== hsci_buffer.sv ====
// both ports writing one address in the same cycle gives an undefined word; reads return old data
`timescale 1ns/10ps
`default_nettype none
`include "hsci_config.svh"

module hsci_buffer import hsci_pkg::*; (
  input  logic          hsci_pclk,
  input  hsci_buf_req_t req_a,
  input  hsci_buf_req_t req_b,
  output hsci_word_u    rdata_a,
  output hsci_word_u    rdata_b
);

  localparam int DEPTH = 1 << `HSCI_BUF_AW;

  hsci_word_u mem [DEPTH];

  // port a for the host, port b for the engine
  // read data holds until the port is enabled again
  always_ff @(posedge hsci_pclk) begin
    if (req_a.en) begin
      if (req_a.we)
        mem[req_a.addr] <= req_a.wdata;
      rdata_a <= mem[req_a.addr];
    end
    if (req_b.en) begin
      if (req_b.we)
        mem[req_b.addr] <= req_b.wdata;
      rdata_b <= mem[req_b.addr];
    end
  end

endmodule

`default_nettype wire

// ==== hsci_config.svh ====
// build-time sizes only; the slave must use the same turnaround count, which must be at least 1
`ifndef HSCI_CONFIG_SVH
`define HSCI_CONFIG_SVH

// ************************************************************
// buffer and register port sizes
// ************************************************************

// word buffer address width, 256 words of 32 bits
`define HSCI_BUF_AW 8

// host register address width
`define HSCI_REG_AW 3

// ************************************************************
// lane timing
// ************************************************************

// idle cycles from the header parity byte to the first miso byte
`define HSCI_TURN_CYCLES 3

`endif

// ==== hsci_lane_shifter.sv ====
// miso_valid marks only the first byte of a run; bytes then follow with no gap until rx_en falls
`timescale 1ns/10ps
`default_nettype none

module hsci_lane_shifter import hsci_pkg::*; (
  input  logic       hsci_pclk,
  input  logic       rst_n,
  input  logic       tx_load,
  input  hsci_word_u tx_word,
  input  hsci_slot_t slot,
  output logic [7:0] mosi_data,
  output logic       mosi_valid,
  input  logic       rx_en,
  input  logic [7:0] miso_data,
  input  logic       miso_valid,
  output hsci_word_u rx_word,
  output logic       rx_valid,
  output logic       parity_err,
  input  logic       clear_errors
);

  hsci_word_u  tx_q;
  logic        tx_active_q;
  logic [31:0] rx_sh_q;
  logic [2:0]  rx_idx_q;
  logic        rx_busy_q;
  logic        rx_take;
  logic        rx_par;

  // ************************************************************
  // mosi side
  // ************************************************************

  // byte picked by the timer slot, msb first, parity in slot 4
  always_comb begin
    mosi_valid = tx_active_q;
    case (slot.slot)
      3'd0:    mosi_data = tx_q.data[31:24];
      3'd1:    mosi_data = tx_q.data[23:16];
      3'd2:    mosi_data = tx_q.data[15:8];
      3'd3:    mosi_data = tx_q.data[7:0];
      default: mosi_data = {7'd0, ^tx_q.data};
    endcase
    // quiet lane between transfers
    if (!tx_active_q)
      mosi_data = 8'd0;
  end

  // ************************************************************
  // miso side
  // ************************************************************

  assign rx_take = rx_en && (rx_busy_q || miso_valid);
  assign rx_par  = rx_take && (rx_idx_q == 3'd4);

  always_ff @(posedge hsci_pclk or negedge rst_n) begin
    if (!rst_n) begin
      tx_active_q <= 1'b0;
      rx_busy_q   <= 1'b0;
      rx_idx_q    <= '0;
      rx_valid    <= 1'b0;
      parity_err  <= 1'b0;
    end else begin
      // a reload in slot 4 keeps the lane busy
      if (tx_load)
        tx_active_q <= 1'b1;
      else if (slot.word_end)
        tx_active_q <= 1'b0;
      rx_valid <= rx_par;
      if (!rx_en) begin
        rx_busy_q <= 1'b0;
        rx_idx_q  <= '0;
      end else if (rx_take) begin
        rx_busy_q <= 1'b1;
        rx_idx_q  <= rx_par ? 3'd0 : rx_idx_q + 3'd1;
      end
      // sticky, any bit off in the parity byte counts
      if (clear_errors)
        parity_err <= 1'b0;
      else if (rx_par && (miso_data != {7'd0, ^rx_sh_q}))
        parity_err <= 1'b1;
    end
  end

  always_ff @(posedge hsci_pclk) begin
    if (tx_load)
      tx_q <= tx_word;
    if (rx_take && !rx_par)
      rx_sh_q <= {rx_sh_q[23:0], miso_data};
    if (rx_par)
      rx_word.data <= rx_sh_q;
  end

endmodule

`default_nettype wire

// ==== hsci_master_top.sv ====
// single clock domain on hsci_pclk; no link training, the slave is assumed ready after reset
`timescale 1ns/10ps
`default_nettype none
`include "hsci_config.svh"

module hsci_master_top import hsci_pkg::*; (
  input  logic                    hsci_pclk,
  input  logic                    rst_n,
  input  logic                    reg_wr_en,
  input  logic [`HSCI_REG_AW-1:0] reg_waddr,
  input  logic [31:0]             reg_wdata,
  input  logic                    reg_rd_en,
  input  logic [`HSCI_REG_AW-1:0] reg_raddr,
  output logic [31:0]             reg_rdata,
  output logic                    reg_rd_valid,
  output logic [7:0]              hsci_mosi_data,
  output logic                    hsci_mosi_valid,
  input  logic [7:0]              hsci_miso_data,
  input  logic                    hsci_miso_valid
);

  hsci_ctrl_t         ctrl;
  hsci_buf_req_t      host_req;
  hsci_buf_req_t      eng_req;
  hsci_word_u         host_rdata;
  hsci_word_u         eng_rdata;
  hsci_word_u         tx_word;
  hsci_word_u         rx_word;
  hsci_slot_t         slot;
  wire  hsci_status_t status;
  logic               timer_start;
  logic               turn_start;
  logic               timer_stop;
  logic               tx_load;
  logic               rx_en;
  logic               rx_valid;

  // host register map
  hsci_regs i_regs (
    .hsci_pclk    (hsci_pclk),
    .rst_n        (rst_n),
    .reg_wr_en    (reg_wr_en),
    .reg_waddr    (reg_waddr),
    .reg_wdata    (reg_wdata),
    .reg_rd_en    (reg_rd_en),
    .reg_raddr    (reg_raddr),
    .reg_rdata    (reg_rdata),
    .reg_rd_valid (reg_rd_valid),
    .ctrl         (ctrl),
    .host_req     (host_req),
    .host_rdata   (host_rdata),
    .status       (status));

  // command and payload words, host on a, engine on b
  hsci_buffer i_buffer (
    .hsci_pclk (hsci_pclk),
    .req_a     (host_req),
    .req_b     (eng_req),
    .rdata_a   (host_rdata),
    .rdata_b   (eng_rdata));

  hsci_xfer_fsm i_xfer_fsm (
    .hsci_pclk   (hsci_pclk),
    .rst_n       (rst_n),
    .ctrl        (ctrl),
    .eng_req     (eng_req),
    .eng_rdata   (eng_rdata),
    .timer_start (timer_start),
    .turn_start  (turn_start),
    .timer_stop  (timer_stop),
    .slot        (slot),
    .tx_load     (tx_load),
    .tx_word     (tx_word),
    .rx_en       (rx_en),
    .rx_word     (rx_word),
    .rx_valid    (rx_valid),
    .running     (status.running),
    .done        (status.done),
    .wr_in_prog  (status.wr_in_prog),
    .rd_in_prog  (status.rd_in_prog));

  hsci_bit_timer i_bit_timer (
    .hsci_pclk  (hsci_pclk),
    .rst_n      (rst_n),
    .start      (timer_start),
    .turn_start (turn_start),
    .stop       (timer_stop),
    .slot       (slot));

  // byte lanes, parity error is the only status bit from here
  hsci_lane_shifter i_lane_shifter (
    .hsci_pclk    (hsci_pclk),
    .rst_n        (rst_n),
    .tx_load      (tx_load),
    .tx_word      (tx_word),
    .slot         (slot),
    .mosi_data    (hsci_mosi_data),
    .mosi_valid   (hsci_mosi_valid),
    .rx_en        (rx_en),
    .miso_data    (hsci_miso_data),
    .miso_valid   (hsci_miso_valid),
    .rx_word      (rx_word),
    .rx_valid     (rx_valid),
    .parity_err   (status.parity_err),
    .clear_errors (ctrl.clear_errors));

endmodule

`default_nettype wire

// ==== hsci_pkg.sv ====
// shared types of the master; widths come from hsci_config.svh, which must be compiled first
`default_nettype none
`include "hsci_config.svh"

package hsci_pkg;

  // command header, first word of a transfer in the buffer
  typedef struct packed {
    logic        dir;
    logic [6:0]  rsvd;
    logic [7:0]  count;
    logic [15:0] slave_addr;
  } hsci_hdr_t;

  // one buffer word, seen as header or as payload
  typedef union packed {
    hsci_hdr_t   hdr;
    logic [31:0] data;
  } hsci_word_u;

  // register side to transfer engine
  typedef struct packed {
    logic                    run;
    logic                    clear_errors;
    logic [`HSCI_BUF_AW-1:0] start_addr;
  } hsci_ctrl_t;

  // status readback, msb first as in the STATUS register
  typedef struct packed {
    logic running;
    logic done;
    logic wr_in_prog;
    logic rd_in_prog;
    logic parity_err;
  } hsci_status_t;

  // request on one buffer port
  typedef struct packed {
    logic                    en;
    logic                    we;
    logic [`HSCI_BUF_AW-1:0] addr;
    hsci_word_u              wdata;
  } hsci_buf_req_t;

  // byte slot within a frame, plus turnaround end
  typedef struct packed {
    logic [2:0] slot;
    logic       word_end;
    logic       turn_done;
  } hsci_slot_t;

endpackage

`default_nettype wire

// ==== hsci_regs.sv ====
// host strobes are single cycle; a BUF_DATA write and a BUF_DATA read in one cycle make one access
`timescale 1ns/10ps
`default_nettype none
`include "hsci_config.svh"

module hsci_regs import hsci_pkg::*; (
  input  logic                    hsci_pclk,
  input  logic                    rst_n,
  input  logic                    reg_wr_en,
  input  logic [`HSCI_REG_AW-1:0] reg_waddr,
  input  logic [31:0]             reg_wdata,
  input  logic                    reg_rd_en,
  input  logic [`HSCI_REG_AW-1:0] reg_raddr,
  output logic [31:0]             reg_rdata,
  output logic                    reg_rd_valid,
  output hsci_ctrl_t              ctrl,
  output hsci_buf_req_t           host_req,
  input  hsci_word_u              host_rdata,
  input  hsci_status_t            status
);

  // ************************************************************
  // register addresses
  // ************************************************************

  localparam logic [`HSCI_REG_AW-1:0] ADDR_CTRL     = 'd0;
  localparam logic [`HSCI_REG_AW-1:0] ADDR_START    = 'd1;
  localparam logic [`HSCI_REG_AW-1:0] ADDR_STATUS   = 'd2;
  localparam logic [`HSCI_REG_AW-1:0] ADDR_BUF_ADDR = 'd3;
  localparam logic [`HSCI_REG_AW-1:0] ADDR_BUF_DATA = 'd4;

  logic [`HSCI_BUF_AW-1:0] buf_addr_q;
  logic [31:0]             rdata_q;
  logic                    rd_buf_q;
  logic                    buf_wr;
  logic                    buf_rd;

  assign buf_wr = reg_wr_en && (reg_waddr == ADDR_BUF_DATA);
  assign buf_rd = reg_rd_en && (reg_raddr == ADDR_BUF_DATA);

  // port a of the buffer, always at the host pointer
  always_comb begin
    host_req.en         = buf_wr || buf_rd;
    host_req.we         = buf_wr;
    host_req.addr       = buf_addr_q;
    host_req.wdata.data = reg_wdata;
  end

  // ************************************************************
  // control registers and pulses
  // ************************************************************

  always_ff @(posedge hsci_pclk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl         <= '0;
      buf_addr_q   <= '0;
      reg_rd_valid <= 1'b0;
      rd_buf_q     <= 1'b0;
    end else begin
      // ctrl bits give one-cycle pulses, nothing is held
      ctrl.run          <= reg_wr_en && (reg_waddr == ADDR_CTRL) && reg_wdata[0];
      ctrl.clear_errors <= reg_wr_en && (reg_waddr == ADDR_CTRL) && reg_wdata[1];
      if (reg_wr_en && (reg_waddr == ADDR_START))
        ctrl.start_addr <= reg_wdata[`HSCI_BUF_AW-1:0];
      // a pointer write beats the auto increment
      if (reg_wr_en && (reg_waddr == ADDR_BUF_ADDR))
        buf_addr_q <= reg_wdata[`HSCI_BUF_AW-1:0];
      else if (host_req.en)
        buf_addr_q <= buf_addr_q + 1'b1;
      reg_rd_valid <= reg_rd_en;
      rd_buf_q     <= buf_rd;
    end
  end

  // ************************************************************
  // readback
  // ************************************************************

  // buf_data answered by the buffer itself one cycle later
  always_ff @(posedge hsci_pclk) begin
    if (reg_rd_en) begin
      case (reg_raddr)
        ADDR_START:    rdata_q <= 32'(ctrl.start_addr);
        ADDR_STATUS:   rdata_q <= 32'(status);
        ADDR_BUF_ADDR: rdata_q <= 32'(buf_addr_q);
        default:       rdata_q <= '0;
      endcase
    end
  end

  assign reg_rdata = rd_buf_q ? host_rdata.data : rdata_q;

endmodule

`default_nettype wire

// ==== hsci_xfer_fsm.sv ====
// one transfer at a time; a run while busy is dropped and the slave must keep pace with the frames
`timescale 1ns/10ps
`default_nettype none
`include "hsci_config.svh"

module hsci_xfer_fsm import hsci_pkg::*; (
  input  logic          hsci_pclk,
  input  logic          rst_n,
  input  hsci_ctrl_t    ctrl,
  output hsci_buf_req_t eng_req,
  input  hsci_word_u    eng_rdata,
  output logic          timer_start,
  output logic          turn_start,
  output logic          timer_stop,
  input  hsci_slot_t    slot,
  output logic          tx_load,
  output hsci_word_u    tx_word,
  output logic          rx_en,
  input  hsci_word_u    rx_word,
  input  logic          rx_valid,
  output logic          running,
  output logic          done,
  output logic          wr_in_prog,
  output logic          rd_in_prog
);

  typedef enum logic [2:0] {IDLE, FETCH_HDR, SEND, TURN, RECV, FINISH} state_t;

  state_t                  state_q;
  logic                    dir_q;
  logic [7:0]              left_q;
  logic [`HSCI_BUF_AW-1:0] ptr_q;
  logic                    more_tx;
  logic                    rd_wait;

  // payload still to send, or words still to receive
  assign more_tx = !dir_q && (left_q != 8'd0);
  assign rd_wait = dir_q && (left_q != 8'd0);

  // ************************************************************
  // buffer, timer and shifter steering
  // ************************************************************

  always_comb begin
    eng_req     = '0;
    tx_load     = 1'b0;
    tx_word     = eng_rdata;
    timer_start = 1'b0;
    turn_start  = 1'b0;
    timer_stop  = 1'b0;
    case (state_q)
      IDLE: begin
        // header read
        if (ctrl.run) begin
          eng_req.en   = 1'b1;
          eng_req.addr = ctrl.start_addr;
        end
      end
      FETCH_HDR: begin
        // header goes out, first payload word read behind it
        tx_load      = 1'b1;
        timer_start  = 1'b1;
        eng_req.en   = 1'b1;
        eng_req.addr = ptr_q;
      end
      SEND: begin
        if (slot.word_end) begin
          if (more_tx) begin
            // load the prefetched word, fetch the next one
            tx_load      = 1'b1;
            eng_req.en   = 1'b1;
            eng_req.addr = ptr_q;
          end else begin
            timer_stop = 1'b1;
          end
          turn_start = rd_wait;
        end
      end
      RECV: begin
        if (rx_valid) begin
          eng_req.en    = 1'b1;
          eng_req.we    = 1'b1;
          eng_req.addr  = ptr_q;
          eng_req.wdata = rx_word;
        end
      end
      default: ;
    endcase
  end

  // ************************************************************
  // state and counters
  // ************************************************************

  always_ff @(posedge hsci_pclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      dir_q   <= 1'b0;
      left_q  <= '0;
      ptr_q   <= '0;
      done    <= 1'b0;
    end else begin
      if (ctrl.clear_errors)
        done <= 1'b0;
      case (state_q)
        IDLE: begin
          if (ctrl.run) begin
            ptr_q   <= ctrl.start_addr + 1'b1;
            done    <= 1'b0;
            state_q <= FETCH_HDR;
          end
        end
        FETCH_HDR: begin
          dir_q  <= eng_rdata.hdr.dir;
          left_q <= eng_rdata.hdr.count;
          // reads keep the pointer on the first reply slot
          if (!eng_rdata.hdr.dir)
            ptr_q <= ptr_q + 1'b1;
          state_q <= SEND;
        end
        SEND: begin
          if (slot.word_end) begin
            if (more_tx) begin
              left_q <= left_q - 1'b1;
              ptr_q  <= ptr_q + 1'b1;
            end else if (rd_wait) begin
              state_q <= TURN;
            end else begin
              state_q <= FINISH;
            end
          end
        end
        TURN: begin
          if (slot.turn_done)
            state_q <= RECV;
        end
        RECV: begin
          if (rx_valid) begin
            ptr_q  <= ptr_q + 1'b1;
            left_q <= left_q - 1'b1;
            if (left_q == 8'd1)
              state_q <= FINISH;
          end
        end
        FINISH: begin
          // done up in the same cycle that running drops
          done    <= 1'b1;
          state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // receiver armed through the turnaround
  assign rx_en      = (state_q == TURN) || (state_q == RECV);
  assign running    = (state_q != IDLE);
  assign wr_in_prog = (state_q == SEND) && !dir_q;
  assign rd_in_prog = dir_q && ((state_q == SEND) || rx_en);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_hsci_master -o sim_hsci_master

out="$(./obj_dir/sim_hsci_master)"
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1

// ==== tb_hsci_master.sv ====
// single clock testbench; the slave model keeps pace and answers after the turnaround idle cycles
`timescale 1ns/10ps
`default_nettype none
`include "hsci_config.svh"

module tb_hsci_master import hsci_pkg::*; ();

  localparam logic [`HSCI_REG_AW-1:0] REG_CTRL     = 'd0;
  localparam logic [`HSCI_REG_AW-1:0] REG_START    = 'd1;
  localparam logic [`HSCI_REG_AW-1:0] REG_STATUS   = 'd2;
  localparam logic [`HSCI_REG_AW-1:0] REG_BUF_ADDR = 'd3;
  localparam logic [`HSCI_REG_AW-1:0] REG_BUF_DATA = 'd4;

  // one transfer per row, name is eight characters
  typedef struct packed {
    logic [63:0]             name;
    logic                    dir;
    logic [7:0]              count;
    logic [`HSCI_BUF_AW-1:0] start_addr;
    logic                    inject_err;
    logic                    rerun;
  } row_t;

  localparam int NUM_ROWS = 5;
  localparam row_t ROWS [NUM_ROWS] = '{
    {"wr_short", 1'b0, 8'd1, 8'h10, 1'b0, 1'b0},
    {"wr_multi", 1'b0, 8'd6, 8'h20, 1'b0, 1'b0},
    {"rd_three", 1'b1, 8'd3, 8'h40, 1'b0, 1'b0},
    {"rd_parer", 1'b1, 8'd2, 8'h60, 1'b1, 1'b0},
    {"wr_rerun", 1'b0, 8'd4, 8'h80, 1'b0, 1'b1}
  };

  logic                    hsci_pclk = 1'b0;
  logic                    rst_n = 1'b0;
  logic                    reg_wr_en;
  logic [`HSCI_REG_AW-1:0] reg_waddr;
  logic [31:0]             reg_wdata;
  logic                    reg_rd_en;
  logic [`HSCI_REG_AW-1:0] reg_raddr;
  logic [31:0]             reg_rdata;
  logic                    reg_rd_valid;
  logic [7:0]              hsci_mosi_data;
  logic                    hsci_mosi_valid;
  logic [7:0]              hsci_miso_data = 8'd0;
  logic                    hsci_miso_valid = 1'b0;

  logic [31:0] lfsr;
  int          err_value = 0;
  int          err_timeout = 0;
  int          err_other = 0;
  // expected lane bytes and reply words, owned by the main process
  logic [7:0]  exp_q [$];
  logic [31:0] reply_q [$];
  logic        slave_rd = 1'b0;
  logic        slave_err = 1'b0;
  int          slave_cnt = 0;
  // slave model state
  logic [7:0]  mosi_q [$];
  logic        mosi_prev = 1'b0;
  int          bursts = 0;
  int          slave_mode = 0;
  int          slave_idle = 0;
  int          slave_byte = 0;

  always #50 hsci_pclk = ~hsci_pclk;

  hsci_master_top dut (
    .hsci_pclk       (hsci_pclk),
    .rst_n           (rst_n),
    .reg_wr_en       (reg_wr_en),
    .reg_waddr       (reg_waddr),
    .reg_wdata       (reg_wdata),
    .reg_rd_en       (reg_rd_en),
    .reg_raddr       (reg_raddr),
    .reg_rdata       (reg_rdata),
    .reg_rd_valid    (reg_rd_valid),
    .hsci_mosi_data  (hsci_mosi_data),
    .hsci_mosi_valid (hsci_mosi_valid),
    .hsci_miso_data  (hsci_miso_data),
    .hsci_miso_valid (hsci_miso_valid));

  // ************************************************************
  // lfsr and frame helpers
  // ************************************************************

  // fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  task automatic next_rand_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      w    = {w[30:0], lfsr[0]};
    end
  endtask

  // msb byte first, byte 4 carries the xor of all data bits
  function automatic logic [7:0] frame_byte(input logic [31:0] w, input int pos);
    if (pos == 4)
      return {7'd0, ^w};
    return w[31 - 8 * pos -: 8];
  endfunction

  task automatic push_frame(input logic [31:0] w);
    for (int pos = 0; pos < 5; pos++)
      exp_q.push_back(frame_byte(w, pos));
  endtask

  // ************************************************************
  // slave model, samples and drives at the falling edge
  // ************************************************************

  always @(negedge hsci_pclk) begin : slave_model
    int          k;
    int          pos;
    logic [7:0]  b;
    if (hsci_mosi_valid) begin
      mosi_q.push_back(hsci_mosi_data);
      if (!mosi_prev)
        bursts++;
    end else if (mosi_prev && slave_rd) begin
      // header frame just ended
      slave_mode = 1;
      slave_idle = 0;
    end
    mosi_prev = hsci_mosi_valid;
    case (slave_mode)
      1: begin
        slave_idle++;
        if (slave_idle == `HSCI_TURN_CYCLES) begin
          slave_mode = 2;
          slave_byte = 0;
        end
      end
      2: begin
        k   = slave_byte / 5;
        pos = slave_byte % 5;
        b   = frame_byte(reply_q[k], pos);
        // bad parity on the first word only
        if (pos == 4 && slave_err && k == 0)
          b = b ^ 8'h01;
        hsci_miso_data  = b;
        hsci_miso_valid = (slave_byte == 0);
        slave_byte++;
        if (slave_byte == slave_cnt * 5)
          slave_mode = 3;
      end
      3: begin
        hsci_miso_data  = 8'd0;
        hsci_miso_valid = 1'b0;
        slave_mode      = 0;
      end
      default: ;
    endcase
  end

  // ************************************************************
  // host port and compare tasks
  // ************************************************************

  task automatic reg_write(input logic [`HSCI_REG_AW-1:0] addr, input logic [31:0] data);
    @(negedge hsci_pclk);
    reg_wr_en = 1'b1;
    reg_waddr = addr;
    reg_wdata = data;
    @(negedge hsci_pclk);
    reg_wr_en = 1'b0;
  endtask

  task automatic reg_read(input logic [`HSCI_REG_AW-1:0] addr, output logic [31:0] data);
    int n;
    @(negedge hsci_pclk);
    reg_rd_en = 1'b1;
    reg_raddr = addr;
    @(negedge hsci_pclk);
    reg_rd_en = 1'b0;
    n = 0;
    while (!reg_rd_valid && n < 8) begin
      @(negedge hsci_pclk);
      n++;
    end
    data = reg_rdata;
    if (!reg_rd_valid) begin
      err_timeout++;
      $display("ERROR: no read response for register %0d", addr);
    end
  endtask

  task automatic check_word(input string name, input hsci_word_u exp, input hsci_word_u act);
    if (exp !== act) begin
      err_value++;
      $display("FAILED %s: expected %08h actual %08h", name, exp.data, act.data);
    end
  endtask

  task automatic check_status(input string name, input hsci_status_t exp,
                              input hsci_status_t act);
    if (exp !== act) begin
      err_value++;
      $display("FAILED %s: expected %05b actual %05b", name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      err_value++;
      $display("FAILED %s: expected %02h actual %02h", name, exp, act);
    end
  endtask

  // poll STATUS until done
  task automatic wait_done(input string name);
    logic [31:0]  rd;
    hsci_status_t st;
    int           n;
    st = '0;
    n  = 0;
    while (!st.done && n < 500) begin
      reg_read(REG_STATUS, rd);
      st = hsci_status_t'(rd[4:0]);
      n++;
    end
    if (!st.done) begin
      err_timeout++;
      $display("ERROR %s: transfer never reported done", name);
    end
  endtask

  // ************************************************************
  // tests
  // ************************************************************

  task automatic buffer_loopback();
    logic [31:0] words [$];
    logic [31:0] rd;
    reg_write(REG_BUF_ADDR, 32'h0000_00c0);
    for (int k = 0; k < 8; k++) begin
      next_rand_word(rd);
      words.push_back(rd);
      reg_write(REG_BUF_DATA, rd);
    end
    // pointer back to the first word, reads auto increment too
    reg_write(REG_BUF_ADDR, 32'h0000_00c0);
    for (int k = 0; k < 8; k++) begin
      reg_read(REG_BUF_DATA, rd);
      check_word($sformatf("buf_loop word %0d", k), words[k], rd);
    end
  endtask

  task automatic run_row(input row_t r);
    string        name;
    hsci_word_u   w;
    hsci_status_t exp_st;
    logic [31:0]  rd;
    int           base_b;
    int           base_bursts;
    name = $sformatf("%s", r.name);
    exp_q.delete();
    reply_q.delete();
    w.hdr.dir        = r.dir;
    w.hdr.rsvd       = '0;
    w.hdr.count      = r.count;
    w.hdr.slave_addr = {8'ha5, r.start_addr};
    reg_write(REG_BUF_ADDR, 32'(r.start_addr));
    reg_write(REG_BUF_DATA, w.data);
    push_frame(w.data);
    // payload into the buffer for writes, reply words for reads
    for (int k = 0; k < int'(r.count); k++) begin
      next_rand_word(rd);
      if (r.dir) begin
        reply_q.push_back(rd);
      end else begin
        reg_write(REG_BUF_DATA, rd);
        push_frame(rd);
      end
    end
    slave_rd    = r.dir;
    slave_cnt   = int'(r.count);
    slave_err   = r.inject_err;
    base_b      = mosi_q.size();
    base_bursts = bursts;
    reg_write(REG_START, 32'(r.start_addr));
    reg_write(REG_CTRL, 32'd1);
    // header frame on the lane, direction flag up
    @(negedge hsci_pclk);
    reg_read(REG_STATUS, rd);
    exp_st            = '0;
    exp_st.running    = 1'b1;
    exp_st.wr_in_prog = !r.dir;
    exp_st.rd_in_prog = r.dir;
    check_status({name, " busy"}, exp_st, hsci_status_t'(rd[4:0]));
    // second run lands mid transfer
    if (r.rerun) begin
      repeat (3) @(negedge hsci_pclk);
      reg_write(REG_CTRL, 32'd1);
    end
    wait_done(name);
    reg_read(REG_STATUS, rd);
    exp_st            = '0;
    exp_st.done       = 1'b1;
    exp_st.parity_err = r.inject_err;
    check_status({name, " status"}, exp_st, hsci_status_t'(rd[4:0]));
    if (mosi_q.size() - base_b != exp_q.size()) begin
      err_other++;
      $display("ERROR %s: %0d mosi bytes seen, %0d expected", name,
               mosi_q.size() - base_b, exp_q.size());
    end else begin
      for (int k = 0; k < exp_q.size(); k++)
        check_byte($sformatf("%s byte %0d", name, k), exp_q[k], mosi_q[base_b + k]);
    end
    if (bursts - base_bursts != 1) begin
      err_other++;
      $display("ERROR %s: mosi valid broke into %0d runs", name, bursts - base_bursts);
    end
    // received words sit right after the header
    if (r.dir) begin
      reg_write(REG_BUF_ADDR, 32'(r.start_addr + 1'b1));
      for (int k = 0; k < int'(r.count); k++) begin
        reg_read(REG_BUF_DATA, rd);
        check_word($sformatf("%s word %0d", name, k), reply_q[k], rd);
      end
    end
    reg_write(REG_CTRL, 32'd2);
    reg_read(REG_STATUS, rd);
    check_status({name, " cleared"}, '0, hsci_status_t'(rd[4:0]));
  endtask

  initial begin
    logic [31:0] rd;
    reg_wr_en = 1'b0;
    reg_waddr = '0;
    reg_wdata = '0;
    reg_rd_en = 1'b0;
    reg_raddr = '0;
    lfsr      = 32'd98805;
    repeat (2) @(negedge hsci_pclk);
    rst_n = 1'b1;
    reg_read(REG_STATUS, rd);
    check_status("reset status", '0, hsci_status_t'(rd[4:0]));
    repeat (5) @(negedge hsci_pclk);
    if (mosi_q.size() != 0) begin
      err_other++;
      $display("ERROR reset: mosi lane went active with no transfer");
    end
    buffer_loopback();
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(ROWS[i]);
    $display("summary: %0d value errors, %0d timeouts, %0d other errors",
             err_value, err_timeout, err_other);
    if (err_value + err_timeout + err_other == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire
